/* design/cpu_pkg.sv */
package cpu_pkg;

	// Basic word types
	typedef logic [31:0] word_t;      // General data word
	typedef logic [31:0] inst_addr_t; // Instruction address
	typedef logic        bit_t;
	typedef logic [4:0]  reg_addr_t;  // GPR index
	typedef logic [7:0]  fcc_t;       // FPU condition codes

	// Immediate format, also covers R-type funct in offset[5:0]
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] offset;
	} inst_i_t;

	// Jump format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] instr_index;
	} inst_j_t;

	// Same 32-bit word, two views
	typedef union packed {
		inst_i_t i;
		inst_j_t j;
	} inst_t;

	// Boot vector, kseg1 ROM
	localparam inst_addr_t RESET_PC  = 32'hbfc0_0000;
	localparam word_t      ZERO_WORD = 32'h0000_0000;

	// Major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_COP1    = 6'b010001;

	// SPECIAL funct codes for register jumps
	localparam logic [5:0] FUNCT_JR   = 6'b001000;
	localparam logic [5:0] FUNCT_JALR = 6'b001001;

	// rs field of BC1F/BC1T
	localparam logic [4:0] COP1_BC = 5'b01000;

	// sll r0, r0, 0
	localparam inst_t NOP_INST = 32'h0000_0000;

endpackage

/* design/fetch_pc.sv */
`timescale 1ns/100ps

module fetch_pc (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,   // Hold current pc
	input  cpu_pkg::bit_t       jump,    // Redirect from decode
	input  cpu_pkg::inst_addr_t jump_to, // Redirect target
	output cpu_pkg::inst_addr_t pc
);

	cpu_pkg::inst_addr_t pc_q;
	cpu_pkg::inst_addr_t pc_next;
	cpu_pkg::inst_addr_t pc_seq;

	assign pc_seq = pc_q + 32'd4; // Sequential fetch

	// Next pc select
	// Decode sees the branch while fetch already has the delay slot,
	// so taking jump_to here never skips the slot
	always_comb begin
		if (jump) begin
			pc_next = jump_to;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= cpu_pkg::RESET_PC; // Boot vector
		end else if (!stall) begin
			pc_q <= pc_next;
		end
	end

	assign pc = pc_q; // Drives the instruction port directly

	// Targets come from decode and registers, so alignment is a cross-module property
	pc_aligned: assert property (
		@(posedge clk) disable iff (rst)
		pc_q[1:0] == 2'b00
	) else $error("fetch pc not word aligned: %h", pc_q);

endmodule

/* design/if_id_reg.sv */
`timescale 1ns/100ps

module if_id_reg (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  cpu_pkg::inst_addr_t if_pc,   // Address presented by fetch
	input  cpu_pkg::inst_t      if_inst, // Word returned this cycle
	output cpu_pkg::inst_addr_t id_pc,
	output cpu_pkg::inst_t      id_inst
);

	cpu_pkg::inst_addr_t pc_q;
	cpu_pkg::inst_t      inst_q;

	// Stage boundary
	// No squash on redirect, the word latched with a taken branch
	// in decode is its delay slot
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q   <= cpu_pkg::RESET_PC;
			inst_q <= cpu_pkg::NOP_INST; // Decode sees a shift, not a branch
		end else if (!stall) begin
			pc_q   <= if_pc;
			inst_q <= if_inst;
		end
	end

	assign id_pc   = pc_q;
	assign id_inst = inst_q;

endmodule

/* design/arch_state.sv */
`timescale 1ns/100ps

module arch_state (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2,
	input  logic               reg_we,
	input  cpu_pkg::reg_addr_t reg_waddr,
	input  cpu_pkg::word_t     reg_wdata,
	input  logic               fcc_we,
	input  logic [2:0]         fcc_idx,   // Condition code select
	input  logic               fcc_wdata,
	output cpu_pkg::fcc_t      fcc
);

	cpu_pkg::word_t regs [1:31]; // r0 not stored
	cpu_pkg::fcc_t  fcc_q;

	// Write side
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= cpu_pkg::ZERO_WORD;
			end
			fcc_q <= '0;
		end else begin
			if (reg_we && reg_waddr != 5'd0) begin
				regs[reg_waddr] <= reg_wdata; // r0 writes dropped
			end
			if (fcc_we) begin
				fcc_q[fcc_idx] <= fcc_wdata;
			end
		end
	end

	// One read port with same-cycle write bypass
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		cpu_pkg::word_t val;
		if (addr == 5'd0) begin
			val = cpu_pkg::ZERO_WORD; // Hardwired zero
		end else if (reg_we && reg_waddr == addr) begin
			val = reg_wdata; // Bypass pending write
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

	// Condition codes, same bypass rule
	always_comb begin
		fcc = fcc_q;
		if (fcc_we) fcc[fcc_idx] = fcc_wdata;
	end

	// An X index would corrupt every bit on write
	fcc_idx_known: assert property (
		@(posedge clk) disable iff (rst)
		fcc_we |-> !$isunknown(fcc_idx)
	) else $error("fcc write with unknown index");

endmodule

/* design/branch.sv */
`timescale 1ns/100ps

module branch (
	input  logic                rst,
	input  cpu_pkg::inst_addr_t pc,        // pc of the decoded instruction
	input  cpu_pkg::inst_t      inst,
	input  cpu_pkg::word_t      reg1,      // rs value
	input  cpu_pkg::word_t      reg2,      // rt value, zero for BLEZ/BGTZ
	input  cpu_pkg::fcc_t       fpu_fcc,
	output cpu_pkg::bit_t       is_branch,
	output cpu_pkg::bit_t       jump,      // Taken
	output cpu_pkg::inst_addr_t jump_to
);

	logic [5:0]          opcode;
	logic [5:0]          funct;
	cpu_pkg::inst_addr_t pc_plus4;
	cpu_pkg::inst_addr_t target_i; // pc-relative
	cpu_pkg::inst_addr_t target_j; // Region jump
	cpu_pkg::bit_t       reg_equal;

	assign opcode = inst.i.opcode;
	assign funct  = inst.i.offset[5:0]; // R-type funct sits in the low bits

	assign pc_plus4 = pc + 32'd4;
	assign target_i = pc_plus4 + {{14{inst.i.offset[15]}}, inst.i.offset, 2'b00};
	assign target_j = {pc_plus4[31:28], inst.j.instr_index, 2'b00}; // Same 256MB region

	assign reg_equal = (reg1 == reg2);

	always_comb begin
		// Default, not a branch
		is_branch = 1'b0;
		jump      = 1'b0;
		jump_to   = cpu_pkg::ZERO_WORD;
		if (!rst) begin
			case (opcode)
				cpu_pkg::OP_SPECIAL: begin
					if (funct == cpu_pkg::FUNCT_JR || funct == cpu_pkg::FUNCT_JALR) begin
						is_branch = 1'b1;
						jump      = 1'b1;
						jump_to   = reg1; // Register target
					end
				end
				cpu_pkg::OP_REGIMM: begin
					// BLTZ 00000, BGEZ 00001, BLTZAL 10000, BGEZAL 10001
					if (inst.i.rt[3:1] == 3'b000) begin
						is_branch = 1'b1;
						jump      = reg1[31] ^ inst.i.rt[0]; // Sign vs. ge bit
						jump_to   = target_i;
					end
				end
				cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BLEZ, cpu_pkg::OP_BGTZ: begin
					// opcode[1] adds the sign term for the compare-with-zero pair
					// opcode[0] turns eq into ne and lez into gtz
					is_branch = 1'b1;
					jump      = ((reg1[31] & opcode[1]) | reg_equal) ^ opcode[0];
					jump_to   = target_i;
				end
				cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
					is_branch = 1'b1;
					jump      = 1'b1;
					jump_to   = target_j;
				end
				cpu_pkg::OP_COP1: begin
					// BC1F/BC1T, cc in rt[4:2], nd in rt[1], tf in rt[0]
					if (inst.i.rs == cpu_pkg::COP1_BC && !inst.i.rt[1]) begin
						is_branch = 1'b1;
						jump      = (fpu_fcc[inst.i.rt[4:2]] == inst.i.rt[0]);
						jump_to   = target_i;
					end
				end
				default: begin
					is_branch = 1'b0; // Everything else is plain
				end
			endcase
		end
	end

	// An X word falls through as plain, X operands give an X redirect
	decision_known: assert final (rst || !$isunknown({inst, is_branch, jump}))
		else $error("unknown branch decision at pc %h", pc);

endmodule

/* design/id_stage.sv */
`timescale 1ns/100ps

module id_stage (
	input  logic                rst,
	input  cpu_pkg::inst_addr_t id_pc,
	input  cpu_pkg::inst_t      id_inst,
	input  cpu_pkg::word_t      rdata1, // rs operand from register file
	input  cpu_pkg::word_t      rdata2, // rt operand
	input  cpu_pkg::fcc_t       fcc,
	output cpu_pkg::reg_addr_t  raddr1,
	output cpu_pkg::reg_addr_t  raddr2,
	output cpu_pkg::bit_t       is_branch,
	output cpu_pkg::bit_t       jump,
	output cpu_pkg::inst_addr_t jump_to
);

	logic          cmp_zero; // BLEZ/BGTZ compare rs against zero
	cpu_pkg::bit_t br_is_branch;
	cpu_pkg::bit_t br_jump;
	cpu_pkg::inst_addr_t br_jump_to;

	assign cmp_zero = (id_inst.i.opcode == cpu_pkg::OP_BLEZ) ||
	                  (id_inst.i.opcode == cpu_pkg::OP_BGTZ);

	// Operand addresses
	assign raddr1 = id_inst.i.rs;
	assign raddr2 = cmp_zero ? 5'd0 : id_inst.i.rt; // r0 gives reg2 == 0

	// Branch resolution in decode
	branch u_branch (
		.rst       (rst),
		.pc        (id_pc),
		.inst      (id_inst),
		.reg1      (rdata1),
		.reg2      (rdata2),
		.fpu_fcc   (fcc),
		.is_branch (br_is_branch),
		.jump      (br_jump),
		.jump_to   (br_jump_to)
	);

	// Results go straight to fetch
	assign is_branch = br_is_branch;
	assign jump      = br_jump;
	assign jump_to   = br_jump_to;

endmodule

/* design/front_end.sv */
`timescale 1ns/100ps

module front_end (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	output cpu_pkg::inst_addr_t inst_addr,  // To instruction memory
	input  cpu_pkg::inst_t      inst_rdata, // Same-cycle response
	input  logic                reg_we,
	input  cpu_pkg::reg_addr_t  reg_waddr,
	input  cpu_pkg::word_t      reg_wdata,
	input  logic                fcc_we,
	input  logic [2:0]          fcc_idx,
	input  logic                fcc_wdata,
	output cpu_pkg::inst_addr_t id_pc,
	output cpu_pkg::inst_t      id_inst,
	output cpu_pkg::bit_t       is_branch,
	output cpu_pkg::bit_t       jump,
	output cpu_pkg::inst_addr_t jump_to
);

	cpu_pkg::reg_addr_t raddr1;
	cpu_pkg::reg_addr_t raddr2;
	cpu_pkg::word_t     rdata1;
	cpu_pkg::word_t     rdata2;
	cpu_pkg::fcc_t      fcc;

	// Redirect loops back from decode
	fetch_pc u_fetch_pc (
		.clk     (clk),
		.rst     (rst),
		.stall   (stall),
		.jump    (jump),
		.jump_to (jump_to),
		.pc      (inst_addr)
	);

	if_id_reg u_if_id (
		.clk     (clk),
		.rst     (rst),
		.stall   (stall),
		.if_pc   (inst_addr),
		.if_inst (inst_rdata),
		.id_pc   (id_pc),
		.id_inst (id_inst)
	);

	// Writes come from outside until the back end exists
	arch_state u_arch_state (
		.clk (clk), .rst (rst),
		.raddr1 (raddr1), .raddr2 (raddr2), .rdata1 (rdata1), .rdata2 (rdata2),
		.reg_we (reg_we), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
		.fcc_we (fcc_we), .fcc_idx (fcc_idx), .fcc_wdata (fcc_wdata), .fcc (fcc)
	);

	id_stage u_id_stage (
		.rst (rst), .id_pc (id_pc), .id_inst (id_inst),
		.rdata1 (rdata1), .rdata2 (rdata2), .fcc (fcc),
		.raddr1 (raddr1), .raddr2 (raddr2),
		.is_branch (is_branch), .jump (jump), .jump_to (jump_to)
	);

endmodule

/* test/tb_front_end.sv */
`timescale 1ns/100ps

module tb_front_end;

	localparam int          CLK_PERIOD = 100;
	localparam int          RUN_CYCLES = 30; // Reset, operand writes and a few steps
	localparam int          RUN_COUNT  = 1 + 1 + 16 + 16 + 2 + 8; // Runs over all six tests
	localparam logic [31:0] SEED       = 32'hde18_9cae;
	localparam logic [31:0] R          = cpu_pkg::RESET_PC;

	logic                clk = 1'b0;
	logic                rst;
	logic                stall;
	cpu_pkg::inst_addr_t inst_addr;
	cpu_pkg::inst_t      inst_rdata;
	logic                reg_we;
	cpu_pkg::reg_addr_t  reg_waddr;
	cpu_pkg::word_t      reg_wdata;
	logic                fcc_we;
	logic [2:0]          fcc_idx;
	logic                fcc_wdata;
	cpu_pkg::inst_addr_t id_pc;
	cpu_pkg::inst_t      id_inst;
	cpu_pkg::bit_t       is_branch;
	cpu_pkg::bit_t       jump;
	cpu_pkg::inst_addr_t jump_to;

	logic [31:0] imem [int unsigned]; // Sparse program memory
	int          mem_gen;             // Bumped on every load
	int          checks;
	int          errors;
	int          test_errors;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Combinational instruction port, empty words read as NOP
	always @(inst_addr or mem_gen) begin
		if (imem.exists(inst_addr)) begin
			inst_rdata = imem[inst_addr];
		end else begin
			inst_rdata = cpu_pkg::NOP_INST;
		end
	end

	front_end uut (
		.clk (clk), .rst (rst), .stall (stall),
		.inst_addr (inst_addr), .inst_rdata (inst_rdata),
		.reg_we (reg_we), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
		.fcc_we (fcc_we), .fcc_idx (fcc_idx), .fcc_wdata (fcc_wdata),
		.id_pc (id_pc), .id_inst (id_inst),
		.is_branch (is_branch), .jump (jump), .jump_to (jump_to)
	);

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] off);
		return {op, rs, rt, off};
	endfunction

	// pc + 4 plus the signed word offset
	function automatic logic [31:0] rel_target(input logic [31:0] pc, input logic [15:0] off);
		return pc + 32'd4 + 32'($signed(off)) * 4;
	endfunction

	// Region of the delay slot, index in words
	function automatic logic [31:0] region_target(input logic [31:0] pc, input logic [25:0] idx);
		return ((pc + 32'd4) & 32'hf000_0000) | ({6'd0, idx} << 2);
	endfunction

	task automatic check_value(input string test, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			test_errors++;
			$display("Fail %s %s: expected %h, actual %h", test, what, exp, act);
		end
	endtask

	task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
		imem[addr] = word;
		mem_gen++;
	endtask

	// Reset with fetch held afterwards, so operands can be written first
	task automatic start_run(input string test);
		@(negedge clk);
		rst = 1'b1;
		stall = 1'b1;
		reg_we = 1'b0;
		fcc_we = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value(test, "reset pc", R, inst_addr);
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
		reg_we = 1'b1;
		reg_waddr = idx;
		reg_wdata = val;
		@(negedge clk);
		reg_we = 1'b0;
	endtask

	task automatic write_fcc(input logic [2:0] idx, input logic val);
		fcc_we = 1'b1;
		fcc_idx = idx;
		fcc_wdata = val;
		@(negedge clk);
		fcc_we = 1'b0;
	endtask

	// Branch at p fetched, decoded, then slot and redirect
	task automatic exec_branch(input string test, input logic [31:0] p, input logic taken,
			input logic [31:0] target);
		check_value(test, "fetch pc", p, inst_addr);
		stall = 1'b0;
		@(negedge clk);
		check_value(test, "is_branch", 1, is_branch);
		check_value(test, "jump", taken, jump);
		check_value(test, "jump_to", target, jump_to);
		check_value(test, "id_pc", p, id_pc);
		check_value(test, "id_inst", imem[p], id_inst); // Word latched from memory
		check_value(test, "delay slot pc", p + 4, inst_addr); // Slot fetched regardless
		@(negedge clk);
		check_value(test, "next pc", taken ? target : p + 8, inst_addr);
		check_value(test, "slot is_branch", 0, is_branch);
	endtask

	task automatic finish_test(input string test);
		if (test_errors == 0) begin
			$display("%s: ok", test);
		end else begin
			$display("%s: %0d mismatches", test, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic test_seq_stall();
		string t = "seq_stall";
		imem.delete();
		mem_gen++;
		start_run(t);
		check_value(t, "reset is_branch", 0, is_branch);
		check_value(t, "reset jump", 0, jump);
		check_value(t, "reset jump_to", 0, jump_to);
		check_value(t, "reset id_inst", 0, id_inst);
		stall = 1'b0;
		for (int k = 1; k <= 3; k++) begin
			@(negedge clk);
			check_value(t, "inst_addr", R + 4 * k, inst_addr);
			check_value(t, "id_pc", R + 4 * (k - 1), id_pc); // One word behind
		end
		stall = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_value(t, "stalled inst_addr", R + 12, inst_addr);
			check_value(t, "stalled id_pc", R + 8, id_pc);
		end
		stall = 1'b0;
		@(negedge clk);
		check_value(t, "resumed inst_addr", R + 16, inst_addr);
		check_value(t, "resumed id_pc", R + 12, id_pc);
		finish_test(t);
	endtask

	task automatic test_jumps();
		string       t = "j_jal";
		logic [25:0] idx1;
		logic [25:0] idx2;
		logic [31:0] t1;
		logic [31:0] t2;
		idx1 = 26'($urandom);
		idx2 = 26'($urandom);
		t1 = region_target(R, idx1);
		t2 = region_target(t1, idx2); // JAL at the J target
		imem.delete();
		load_word(R, {cpu_pkg::OP_J, idx1});
		load_word(t1, {cpu_pkg::OP_JAL, idx2});
		start_run(t);
		exec_branch(t, R, 1'b1, t1);
		exec_branch(t, t1, 1'b1, t2);
		finish_test(t);
	endtask

	task automatic test_cond();
		string       t = "beq_bne_blez_bgtz";
		logic [5:0]  ops [4] = '{cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_BLEZ,
			cpu_pkg::OP_BGTZ};
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] off;
		logic        taken;
		for (int o = 0; o < 4; o++) begin
			for (int c = 0; c < 4; c++) begin
				a = $urandom;
				b = $urandom;
				off = 16'($urandom);
				case (c)
					0: a = a & 32'h7fff_ffff; // Positive rs
					1: b = a;                 // Equal operands
					2: a = 32'd0;
					default: a = a | 32'h8000_0000; // Negative rs
				endcase
				case (ops[o])
					cpu_pkg::OP_BEQ: taken = (a == b);
					cpu_pkg::OP_BNE: taken = (a != b);
					cpu_pkg::OP_BLEZ: taken = ($signed(a) <= 0);
					default: taken = ($signed(a) > 0);
				endcase
				imem.delete();
				load_word(R, enc_i(ops[o], 5'd1, 5'd2, off));
				start_run(t);
				write_reg(5'd1, a);
				write_reg(5'd2, b); // Ignored by BLEZ/BGTZ
				exec_branch(t, R, taken, rel_target(R, off));
			end
		end
		finish_test(t);
	endtask

	task automatic test_regimm();
		string       t = "bltz_bgez_al";
		logic [4:0]  rts [4] = '{5'b00000, 5'b00001, 5'b10000, 5'b10001};
		logic [31:0] a;
		logic [15:0] off;
		logic        taken;
		for (int o = 0; o < 4; o++) begin
			for (int c = 0; c < 4; c++) begin
				a = $urandom;
				off = 16'($urandom);
				if (c == 1) a = 32'd0;
				if (c == 2) a = a | 32'h8000_0000;
				if (c == 3) a = a & 32'h7fff_ffff;
				taken = rts[o][0] ? ($signed(a) >= 0) : ($signed(a) < 0); // ge vs lt
				imem.delete();
				load_word(R, enc_i(cpu_pkg::OP_REGIMM, 5'd3, rts[o], off));
				start_run(t);
				write_reg(5'd3, a);
				exec_branch(t, R, taken, rel_target(R, off));
			end
		end
		finish_test(t);
	endtask

	task automatic test_reg_jump();
		string       t = "jr_jalr";
		logic [31:0] v0;
		logic [31:0] v1;
		v0 = $urandom & ~32'h3;
		v1 = $urandom & ~32'h3;
		imem.delete();
		load_word(R, {6'd0, 5'd5, 5'd0, 5'd0, 5'd0, cpu_pkg::FUNCT_JR});
		start_run(t);
		write_reg(5'd5, v0);
		exec_branch(t, R, 1'b1, v0);
		// JALR whose rs is rewritten while it sits in decode
		imem.delete();
		load_word(R, {6'd0, 5'd7, 5'd0, 5'd31, 5'd0, cpu_pkg::FUNCT_JALR});
		start_run(t);
		write_reg(5'd7, v0);
		stall = 1'b0;
		@(negedge clk);
		check_value(t, "old jump_to", v0, jump_to);
		reg_we = 1'b1;
		reg_waddr = 5'd7;
		reg_wdata = v1;
		#(CLK_PERIOD / 4); // Mid low phase, write still pending
		check_value(t, "bypassed jump_to", v1, jump_to);
		@(negedge clk);
		check_value(t, "bypassed target", v1, inst_addr);
		reg_we = 1'b0;
		finish_test(t);
	endtask

	task automatic test_cop1();
		string       t = "bc1_plain";
		logic [7:0]  cc;
		logic [2:0]  idx;
		logic        tf;
		logic [15:0] off;
		for (int r = 0; r < 6; r++) begin
			cc = 8'($urandom);
			idx = 3'($urandom);
			tf = 1'($urandom);
			off = 16'($urandom);
			imem.delete();
			load_word(R, enc_i(cpu_pkg::OP_COP1, cpu_pkg::COP1_BC, {idx, 1'b0, tf}, off));
			start_run(t);
			for (int i = 0; i < 8; i++) begin
				write_fcc(3'(i), cc[i]);
			end
			exec_branch(t, R, cc[idx] == tf, rel_target(R, off));
		end
		// ADDIU then LW, neither may redirect
		for (int r = 0; r < 2; r++) begin
			imem.delete();
			load_word(R, enc_i(r ? 6'b100011 : 6'b001001, 5'($urandom), 5'($urandom),
				16'($urandom)));
			start_run(t);
			stall = 1'b0;
			@(negedge clk);
			check_value(t, "plain is_branch", 0, is_branch);
			check_value(t, "plain jump", 0, jump);
			check_value(t, "plain jump_to", 0, jump_to);
			@(negedge clk);
			check_value(t, "plain next pc", R + 8, inst_addr);
		end
		finish_test(t);
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		stall = 1'b0;
		reg_we = 1'b0;
		reg_waddr = 5'd0;
		reg_wdata = 32'd0;
		fcc_we = 1'b0;
		fcc_idx = 3'd0;
		fcc_wdata = 1'b0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		mem_gen = 0;
		test_seq_stall();
		test_jumps();
		test_cond();
		test_regimm();
		test_reg_jump();
		test_cop1();
		$display("Summary: %0d checks, %0d passed, %0d failed", checks, checks - errors, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog sized from the run count
	initial begin
		#(RUN_COUNT * RUN_CYCLES * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", RUN_COUNT * RUN_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

/* files.f */
design/cpu_pkg.sv
design/fetch_pc.sv
design/if_id_reg.sv
design/arch_state.sv
design/branch.sv
design/id_stage.sv
design/front_end.sv
test/tb_front_end.sv

/* Bender.yml */
package:
  name: front_end

sources:
  - design/cpu_pkg.sv
  - design/fetch_pc.sv
  - design/if_id_reg.sv
  - design/arch_state.sv
  - design/branch.sv
  - design/id_stage.sv
  - design/front_end.sv
  - target: test
    files:
      - test/tb_front_end.sv
